/* sources.f */
hw/line_pkg.sv
hw/line_cmd_regs.sv
hw/line_setup.sv
hw/line_stepper.sv
hw/pixel_writer.sv
hw/line_engine_top.sv
tests/tb_clock.sv
tests/tb_line_engine.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing
TOP ?= tb_line_engine
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_line_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_line_engine;

	import line_pkg::*;

	localparam int SCREEN_W = 320;
	localparam int SCREEN_H = 240;
	localparam int MAX_LINES = 40;

	wire clk;
	wire n_rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	reg_addr_e wb_adr;
	logic [WB_DW-1:0] wb_dat_w;
	wire wb_ack;
	wire [WB_DW-1:0] wb_dat_r;
	wire fb_cyc;
	wire fb_stb;
	wire fb_we;
	wire [FB_ADR_W-1:0] fb_adr;
	wire [COLOUR_W-1:0] fb_dat;
	logic fb_ack;

	// line table filled before reset is released
	int lx0[MAX_LINES];
	int ly0[MAX_LINES];
	int lx1[MAX_LINES];
	int ly1[MAX_LINES];
	bit lbp[MAX_LINES];
	bit lpoke[MAX_LINES];
	string lname[MAX_LINES];
	int n_lines;
	int limit_cycles;

	logic [31:0] lfsr = 32'h4281;
	bit rand_ack;
	int ack_delay;
	string cur_name;
	logic [COLOUR_W-1:0] exp_colour;
	logic [FB_ADR_W-1:0] exp_adr[$];
	logic [FB_ADR_W-1:0] got_adr[$];
	logic [COLOUR_W-1:0] got_dat[$];
	logic [FB_ADR_W-1:0] pop_a;
	logic [COLOUR_W-1:0] pop_c;
	int err_count;
	int n_tests;
	int n_failed;

	tb_clock u_clock
	(
		.clk(clk),
		.n_rst(n_rst)
	);

	line_engine_top
	#(
		.SCREEN_W(SCREEN_W),
		.SCREEN_H(SCREEN_H)
	)
	DUT
	(
		.clk(clk),
		.n_rst(n_rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_ack(wb_ack),
		.wb_dat_r(wb_dat_r),
		.fb_cyc(fb_cyc),
		.fb_stb(fb_stb),
		.fb_we(fb_we),
		.fb_adr(fb_adr),
		.fb_dat(fb_dat),
		.fb_ack(fb_ack)
	);

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic int rand_bits(input int n);
		int val;
		int i;
		val = 0;
		for (i = 0; i < n; i++)
			val = (val << 1) | int'(lfsr_bit());
		return val;
	endfunction

	function automatic int pixel_count(input int x0, input int y0, input int x1, input int y1);
		int sx;
		int sy;
		sx = (x1 >= x0) ? x1 - x0 + 1 : x0 - x1 + 1;
		sy = (y1 >= y0) ? y1 - y0 + 1 : y0 - y1 + 1;
		return (sy > sx) ? sy : sx;
	endfunction

	// expected addresses by the drawing rule
	function automatic void build_expected(input int x0, input int y0, input int x1, input int y1);
		int sx;
		int sy;
		int maj;
		int mnr;
		int maj_step;
		int mnr_step;
		int span_maj;
		int grad;
		int err;
		int i;
		bit steep;
		sx = (x1 >= x0) ? x1 - x0 + 1 : x0 - x1 + 1;
		sy = (y1 >= y0) ? y1 - y0 + 1 : y0 - y1 + 1;
		steep = sy > sx;
		maj = steep ? y0 : x0;
		mnr = steep ? x0 : y0;
		maj_step = steep ? ((y1 >= y0) ? 1 : -1) : ((x1 >= x0) ? 1 : -1);
		mnr_step = steep ? ((x1 >= x0) ? 1 : -1) : ((y1 >= y0) ? 1 : -1);
		span_maj = steep ? sy : sx;
		grad = ((steep ? sx : sy) * 128) / span_maj;
		err = grad;
		for (i = 0; i < span_maj; i++)
		begin
			if (steep)
				exp_adr.push_back(FB_ADR_W'(maj * SCREEN_W + mnr));
			else
				exp_adr.push_back(FB_ADR_W'(mnr * SCREEN_W + maj));
			maj = maj + maj_step;
			if (err >= 128)
			begin
				mnr = mnr + mnr_step;
				err = err - 128;
			end
			err = err + grad;
		end
	endfunction

	function automatic void add_line(input string name, input int x0, input int y0,
		input int x1, input int y1, input bit bp, input bit poke);
		lname[n_lines] = name;
		lx0[n_lines] = x0;
		ly0[n_lines] = y0;
		lx1[n_lines] = x1;
		ly1[n_lines] = y1;
		lbp[n_lines] = bp;
		lpoke[n_lines] = poke;
		n_lines++;
	endfunction

	function automatic void fill_line_table();
		int i;
		int total;
		add_line("shallow_px_py", 20, 30, 80, 50, 1'b0, 1'b0);
		add_line("shallow_nx_py", 200, 40, 150, 60, 1'b0, 1'b0);
		add_line("shallow_px_ny", 30, 200, 90, 170, 1'b0, 1'b0);
		add_line("shallow_nx_ny", 300, 220, 240, 190, 1'b0, 1'b0);
		add_line("steep_px_py", 50, 10, 70, 90, 1'b0, 1'b0);
		add_line("steep_nx_py", 100, 20, 80, 100, 1'b0, 1'b0);
		add_line("steep_px_ny", 10, 230, 40, 150, 1'b0, 1'b0);
		add_line("steep_nx_ny", 310, 200, 290, 120, 1'b0, 1'b0);
		add_line("horizontal", 0, 120, 319, 120, 1'b0, 1'b0);
		add_line("vertical", 160, 0, 160, 239, 1'b0, 1'b0);
		add_line("diagonal", 10, 10, 60, 60, 1'b0, 1'b0);
		add_line("single_point", 319, 239, 319, 239, 1'b0, 1'b0);
		add_line("backpressure_shallow", 5, 100, 150, 140, 1'b1, 1'b0);
		add_line("backpressure_steep", 250, 5, 200, 200, 1'b1, 1'b0);
		add_line("start_while_busy", 0, 0, 200, 100, 1'b0, 1'b1);
		add_line("start_after_busy", 10, 200, 100, 10, 1'b0, 1'b0);
		for (i = 0; i < 20; i++)
			add_line($sformatf("random_%0d", i), rand_bits(9) % SCREEN_W,
				rand_bits(8) % SCREEN_H, rand_bits(9) % SCREEN_W,
				rand_bits(8) % SCREEN_H, 1'b1, 1'b0);
		total = 0;
		for (i = 0; i < n_lines; i++)
			total = total + pixel_count(lx0[i], ly0[i], lx1[i], ly1[i]);
		limit_cycles = total * 8 + 200;
	endfunction

	task automatic check_adr(input string what, input logic [FB_ADR_W-1:0] exp,
		input logic [FB_ADR_W-1:0] act);
		if (act !== exp)
		begin
			$display("Mismatch in %s (%s): expected %0d, got %0d", cur_name, what, exp, act);
			err_count++;
		end
	endtask

	task automatic check_colour(input string what, input logic [COLOUR_W-1:0] exp,
		input logic [COLOUR_W-1:0] act);
		if (act !== exp)
		begin
			$display("Mismatch in %s (%s): expected %h, got %h", cur_name, what, exp, act);
			err_count++;
		end
	endtask

	task automatic check_reg(input string what, input logic [WB_DW-1:0] exp,
		input logic [WB_DW-1:0] act);
		if (act !== exp)
		begin
			$display("Mismatch in %s (%s): expected %h, got %h", cur_name, what, exp, act);
			err_count++;
		end
	endtask

	// one wishbone classic cycle with data sampled on ack
	task automatic bus_access(input logic we, input logic [2:0] adr,
		input logic [WB_DW-1:0] dat, output logic [WB_DW-1:0] rdat);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= reg_addr_e'(adr);
		wb_dat_w <= dat;
		@(negedge clk);
		while (!wb_ack)
			@(negedge clk);
		rdat = wb_dat_r;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic write_reg(input logic [2:0] adr, input logic [WB_DW-1:0] dat);
		logic [WB_DW-1:0] unused_rd;
		bus_access(1'b1, adr, dat, unused_rd);
	endtask

	task automatic read_reg(input logic [2:0] adr, output logic [WB_DW-1:0] rdat);
		bus_access(1'b0, adr, '0, rdat);
	endtask

	task automatic finish_test(input int errs_before);
		n_tests++;
		if (err_count == errs_before)
			$display("test %s: ok", cur_name);
		else
		begin
			n_failed++;
			$display("test %s: %0d errors", cur_name, err_count - errs_before);
		end
	endtask

	task automatic register_test();
		logic [WB_DW-1:0] rd;
		int errs_before;
		cur_name = "registers";
		errs_before = err_count;
		write_reg(REG_START_X, 16'h0155);
		write_reg(REG_START_Y, 16'h00a3);
		write_reg(REG_END_X, 16'h012c);
		write_reg(REG_END_Y, 16'h005e);
		write_reg(REG_COLOUR, 16'h00c7);
		read_reg(REG_START_X, rd);
		check_reg("start_x", 16'h0155, rd);
		read_reg(REG_START_Y, rd);
		check_reg("start_y", 16'h00a3, rd);
		read_reg(REG_END_X, rd);
		check_reg("end_x", 16'h012c, rd);
		read_reg(REG_END_Y, rd);
		check_reg("end_y", 16'h005e, rd);
		read_reg(REG_COLOUR, rd);
		check_reg("colour", 16'h00c7, rd);
		read_reg(REG_CTRL, rd);
		check_reg("idle status", 16'h0000, rd);
		read_reg(3'd6, rd);
		check_reg("unused 6", 16'h0000, rd);
		read_reg(3'd7, rd);
		check_reg("unused 7", 16'h0000, rd);
		finish_test(errs_before);
	endtask

	task automatic draw_line(input int idx);
		logic [WB_DW-1:0] rd;
		int errs_before;
		cur_name = lname[idx];
		rand_ack = lbp[idx];
		errs_before = err_count;
		exp_colour = COLOUR_W'(idx * 37 + 5);
		write_reg(REG_START_X, WB_DW'(lx0[idx]));
		write_reg(REG_START_Y, WB_DW'(ly0[idx]));
		write_reg(REG_END_X, WB_DW'(lx1[idx]));
		write_reg(REG_END_Y, WB_DW'(ly1[idx]));
		write_reg(REG_COLOUR, WB_DW'(exp_colour));
		build_expected(lx0[idx], ly0[idx], lx1[idx], ly1[idx]);
		write_reg(REG_CTRL, 16'h0001);
		read_reg(REG_CTRL, rd);
		check_reg("busy after start", 16'h0001, rd);
		// a second command mid line must change nothing
		if (lpoke[idx])
		begin
			write_reg(REG_START_X, 16'h0007);
			write_reg(REG_CTRL, 16'h0001);
		end
		read_reg(REG_CTRL, rd);
		while (rd[0])
			read_reg(REG_CTRL, rd);
		// endpoint written mid line must not have landed
		if (lpoke[idx])
		begin
			read_reg(REG_START_X, rd);
			check_reg("start_x held while busy", WB_DW'(lx0[idx]), rd);
		end
		@(posedge clk);
		if (exp_adr.size() != 0)
		begin
			$display("test %s: %0d expected pixels were never written", cur_name,
				exp_adr.size());
			err_count++;
			exp_adr.delete();
		end
		finish_test(errs_before);
	endtask

	// frame buffer slave that records each write and acks after a delay
	initial
	begin
		fb_ack <= 1'b0;
		forever
		begin
			@(negedge clk);
			if (fb_cyc && fb_stb)
			begin
				ack_delay = rand_ack ? rand_bits(2) : 0;
				repeat (ack_delay) @(negedge clk);
				if (!fb_we)
				begin
					$display("test %s: frame buffer cycle without write enable", cur_name);
					err_count++;
				end
				got_adr.push_back(fb_adr);
				got_dat.push_back(fb_dat);
				@(posedge clk);
				fb_ack <= 1'b1;
				@(posedge clk);
				fb_ack <= 1'b0;
			end
		end
	end

	// writes checked in order against the reference list
	always @(posedge clk)
	begin
		if (got_adr.size() > 0)
		begin
			pop_a = got_adr.pop_front();
			pop_c = got_dat.pop_front();
			if (exp_adr.size() == 0)
			begin
				$display("test %s: extra pixel written at address %0d", cur_name, pop_a);
				err_count++;
			end
			else
			begin
				check_adr("address", exp_adr.pop_front(), pop_a);
				check_colour("colour", exp_colour, pop_c);
			end
		end
	end

	initial
	begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout after %0d cycles, the engine stopped responding", limit_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		wb_adr <= REG_START_X;
		wb_dat_w <= '0;
		err_count = 0;
		n_tests = 0;
		n_failed = 0;
		n_lines = 0;
		rand_ack = 1'b0;
		exp_colour = '0;
		cur_name = "reset";
		fill_line_table();
		wait (n_rst);
		@(posedge clk);
		register_test();
		for (int i = 0; i < n_lines; i++)
			draw_line(i);
		$display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, err_count);
		if (err_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock
#(
	parameter int HALF_PERIOD = 50,
	parameter int RST_CYCLES = 8
)
(
	output logic clk,
	output logic n_rst
);

	initial
	begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// reset released on a rising edge
	initial
	begin
		n_rst <= 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		n_rst <= 1'b1;
	end

endmodule

`default_nettype wire

/* hw/line_engine_top.sv */
`timescale 1ns/10ps
`default_nettype none

module line_engine_top
#(
	parameter int SCREEN_W = 320,
	parameter int SCREEN_H = 240
)
(
	input wire clk,
	input wire n_rst,
	// host side
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire line_pkg::reg_addr_e wb_adr,
	input wire [line_pkg::WB_DW-1:0] wb_dat_w,
	output wire wb_ack,
	output wire [line_pkg::WB_DW-1:0] wb_dat_r,
	// frame buffer side
	output wire fb_cyc,
	output wire fb_stb,
	output wire fb_we,
	output wire [line_pkg::FB_ADR_W-1:0] fb_adr,
	output wire [line_pkg::COLOUR_W-1:0] fb_dat,
	input wire fb_ack
);

	import line_pkg::*;

	wire cmd_go;
	wire line_done;
	wire [X_W-1:0] start_x;
	wire [X_W-1:0] end_x;
	wire [Y_W-1:0] start_y;
	wire [Y_W-1:0] end_y;
	wire [COLOUR_W-1:0] colour;

	wire seg_valid;
	wire seg_ready;
	wire swap_xy;
	wire [CRD_W-1:0] major_start;
	wire [CRD_W-1:0] minor_start;
	wire [CRD_W-1:0] major_end;
	wire major_dir;
	wire minor_dir;
	wire [GRAD_W-1:0] gradient;

	wire pix_valid;
	wire pix_ready;
	wire [X_W-1:0] pix_x;
	wire [Y_W-1:0] pix_y;
	wire pix_last;

	line_cmd_regs u_regs
	(
		.clk(clk),
		.n_rst(n_rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.line_done(line_done),
		.wb_ack(wb_ack),
		.wb_dat_r(wb_dat_r),
		.cmd_go(cmd_go),
		.start_x(start_x),
		.end_x(end_x),
		.start_y(start_y),
		.end_y(end_y),
		.colour(colour)
	);

	line_setup u_setup
	(
		.clk(clk),
		.n_rst(n_rst),
		.cmd_go(cmd_go),
		.start_x(start_x),
		.start_y(start_y),
		.end_x(end_x),
		.end_y(end_y),
		.seg_ready(seg_ready),
		.seg_valid(seg_valid),
		.swap_xy(swap_xy),
		.major_start(major_start),
		.minor_start(minor_start),
		.major_end(major_end),
		.major_dir(major_dir),
		.minor_dir(minor_dir),
		.gradient(gradient)
	);

	line_stepper u_stepper
	(
		.clk(clk),
		.n_rst(n_rst),
		.seg_valid(seg_valid),
		.swap_xy(swap_xy),
		.major_start(major_start),
		.minor_start(minor_start),
		.major_end(major_end),
		.major_dir(major_dir),
		.minor_dir(minor_dir),
		.gradient(gradient),
		.pix_ready(pix_ready),
		.seg_ready(seg_ready),
		.pix_valid(pix_valid),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.pix_last(pix_last)
	);

	pixel_writer
	#(
		.SCREEN_W(SCREEN_W),
		.SCREEN_H(SCREEN_H)
	)
	u_writer
	(
		.clk(clk),
		.n_rst(n_rst),
		.pix_valid(pix_valid),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.pix_last(pix_last),
		.colour(colour),
		.fb_ack(fb_ack),
		.pix_ready(pix_ready),
		.fb_cyc(fb_cyc),
		.fb_stb(fb_stb),
		.fb_we(fb_we),
		.fb_adr(fb_adr),
		.fb_dat(fb_dat),
		.line_done(line_done)
	);

endmodule

`default_nettype wire

/* hw/pixel_writer.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_writer
#(
	parameter int SCREEN_W = 320,
	parameter int SCREEN_H = 240
)
(
	input wire clk,
	input wire n_rst,
	input wire pix_valid,
	input wire [line_pkg::X_W-1:0] pix_x,
	input wire [line_pkg::Y_W-1:0] pix_y,
	input wire pix_last,
	input wire [line_pkg::COLOUR_W-1:0] colour,
	input wire fb_ack,
	output logic pix_ready,
	output logic fb_cyc,
	output logic fb_stb,
	output logic fb_we,
	output logic [line_pkg::FB_ADR_W-1:0] fb_adr,
	output logic [line_pkg::COLOUR_W-1:0] fb_dat,
	output logic line_done
);

	import line_pkg::*;

	// just wide enough for every pixel on screen
	localparam int ADR_BITS = $clog2(SCREEN_W * SCREEN_H);

	logic [ADR_BITS-1:0] pix_adr;
	logic last_q;
	logic take;

	assign pix_ready = !fb_cyc;
	assign take = pix_valid && pix_ready;

	// row major word address
	assign pix_adr = ADR_BITS'(pix_y) * ADR_BITS'(SCREEN_W) + ADR_BITS'(pix_x);

	// write only, strobe follows the cycle
	assign fb_stb = fb_cyc;
	assign fb_we = fb_cyc;

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			fb_cyc <= 1'b0;
			line_done <= 1'b0;
		end
		else
		begin
			line_done <= fb_cyc && fb_ack && last_q;
			if (take)
				fb_cyc <= 1'b1;
			else if (fb_cyc && fb_ack)
				fb_cyc <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			fb_adr <= FB_ADR_W'(pix_adr);
			fb_dat <= colour;
			last_q <= pix_last;
		end
	end

endmodule

`default_nettype wire

/* hw/line_stepper.sv */
`timescale 1ns/10ps
`default_nettype none

module line_stepper
(
	input wire clk,
	input wire n_rst,
	input wire seg_valid,
	input wire swap_xy,
	input wire [line_pkg::CRD_W-1:0] major_start,
	input wire [line_pkg::CRD_W-1:0] minor_start,
	input wire [line_pkg::CRD_W-1:0] major_end,
	input wire major_dir,
	input wire minor_dir,
	input wire [line_pkg::GRAD_W-1:0] gradient,
	input wire pix_ready,
	output logic seg_ready,
	output logic pix_valid,
	output logic [line_pkg::X_W-1:0] pix_x,
	output logic [line_pkg::Y_W-1:0] pix_y,
	output logic pix_last
);

	import line_pkg::*;

	localparam logic [GRAD_W-1:0] ONE_STEP = GRAD_W'(1) << FRAC_W;

	step_state_e state;
	logic [CRD_W-1:0] major;
	logic [CRD_W-1:0] minor;
	logic [CRD_W-1:0] major_nxt;
	logic [GRAD_W-1:0] err;
	logic load;
	logic step;

	assign seg_ready = (state == STEP_IDLE);
	assign load = seg_ready && seg_valid;

	// a pixel is on offer in every state but idle
	assign pix_valid = (state != STEP_IDLE);
	assign pix_last = (state == STEP_LAST);
	assign step = pix_valid && pix_ready;

	assign major_nxt = major_dir ? major + CRD_W'(1) : major - CRD_W'(1);

	// back from major/minor to screen axes
	assign pix_x = swap_xy ? minor[X_W-1:0] : major[X_W-1:0];
	assign pix_y = swap_xy ? major[Y_W-1:0] : minor[Y_W-1:0];

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
			state <= STEP_IDLE;
		else
		begin
			case (state)
				STEP_IDLE:
				begin
					// a single point line is last from the start
					if (seg_valid)
						state <= (major_start == major_end) ? STEP_LAST : STEP_RUN;
				end
				STEP_RUN:
				begin
					if (step && (major_nxt == major_end))
						state <= STEP_LAST;
				end
				STEP_LAST:
				begin
					if (step)
						state <= STEP_IDLE;
				end
				default:
					state <= STEP_IDLE;
			endcase
		end
	end

	// position and error only move on an accepted pixel
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			major <= major_start;
			minor <= minor_start;
			err <= gradient;
		end
		else if (step && (state == STEP_RUN))
		begin
			major <= major_nxt;
			if (err >= ONE_STEP)
			begin
				minor <= minor_dir ? minor + CRD_W'(1) : minor - CRD_W'(1);
				err <= err - ONE_STEP + gradient;
			end
			else
				err <= err + gradient;
		end
	end

endmodule

`default_nettype wire

/* hw/line_setup.sv */
`timescale 1ns/10ps
`default_nettype none

module line_setup
(
	input wire clk,
	input wire n_rst,
	input wire cmd_go,
	input wire [line_pkg::X_W-1:0] start_x,
	input wire [line_pkg::Y_W-1:0] start_y,
	input wire [line_pkg::X_W-1:0] end_x,
	input wire [line_pkg::Y_W-1:0] end_y,
	input wire seg_ready,
	output logic seg_valid,
	output logic swap_xy,
	output logic [line_pkg::CRD_W-1:0] major_start,
	output logic [line_pkg::CRD_W-1:0] minor_start,
	output logic [line_pkg::CRD_W-1:0] major_end,
	output logic major_dir,
	output logic minor_dir,
	output logic [line_pkg::GRAD_W-1:0] gradient
);

	import line_pkg::*;

	logic dx_neg;
	logic dy_neg;
	logic swap;
	logic [CRD_W-1:0] span_x;
	logic [CRD_W-1:0] span_y;
	logic [CRD_W-1:0] span_major;
	logic [CRD_W-1:0] span_minor;
	logic [GRAD_W-1:0] grad_next;

	assign dx_neg = end_x < start_x;
	assign dy_neg = end_y < start_y;

	// spans count both end points
	assign span_x = dx_neg ? CRD_W'(start_x - end_x) + CRD_W'(1)
		: CRD_W'(end_x - start_x) + CRD_W'(1);
	assign span_y = dy_neg ? CRD_W'(start_y - end_y) + CRD_W'(1)
		: CRD_W'(end_y - start_y) + CRD_W'(1);

	// steep lines walk along y
	assign swap = span_y > span_x;
	assign span_major = swap ? span_y : span_x;
	assign span_minor = swap ? span_x : span_y;

	// minor/major with FRAC_W fraction bits, never above one step
	assign grad_next = (GRAD_W'(span_minor) << FRAC_W) / GRAD_W'(span_major);

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
			seg_valid <= 1'b0;
		else if (cmd_go)
			seg_valid <= 1'b1;
		else if (seg_ready)
			seg_valid <= 1'b0;
	end

	// results stay put until the next command, the stepper reads them all line long
	always_ff @(posedge clk)
	begin
		if (cmd_go)
		begin
			swap_xy <= swap;
			major_start <= swap ? CRD_W'(start_y) : CRD_W'(start_x);
			minor_start <= swap ? CRD_W'(start_x) : CRD_W'(start_y);
			major_end <= swap ? CRD_W'(end_y) : CRD_W'(end_x);
			major_dir <= swap ? !dy_neg : !dx_neg;
			minor_dir <= swap ? !dx_neg : !dy_neg;
			gradient <= grad_next;
		end
	end

endmodule

`default_nettype wire

/* hw/line_cmd_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module line_cmd_regs
(
	input wire clk,
	input wire n_rst,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire line_pkg::reg_addr_e wb_adr,
	input wire [line_pkg::WB_DW-1:0] wb_dat_w,
	input wire line_done,
	output logic wb_ack,
	output logic [line_pkg::WB_DW-1:0] wb_dat_r,
	output logic cmd_go,
	output logic [line_pkg::X_W-1:0] start_x,
	output logic [line_pkg::X_W-1:0] end_x,
	output logic [line_pkg::Y_W-1:0] start_y,
	output logic [line_pkg::Y_W-1:0] end_y,
	output logic [line_pkg::COLOUR_W-1:0] colour
);

	import line_pkg::*;

	logic busy;
	logic access;
	logic start_req;
	logic go;
	logic [WB_DW-1:0] rd_data;

	// one ack per cycle, so the second edge of a held strobe is not a new access
	assign access = wb_cyc && wb_stb && !wb_ack;
	assign start_req = access && wb_we && (wb_adr == REG_CTRL) && wb_dat_w[0];
	assign go = start_req && !busy;

	always_comb
	begin
		case (wb_adr)
			REG_START_X: rd_data = WB_DW'(start_x);
			REG_START_Y: rd_data = WB_DW'(start_y);
			REG_END_X: rd_data = WB_DW'(end_x);
			REG_END_Y: rd_data = WB_DW'(end_y);
			REG_COLOUR: rd_data = WB_DW'(colour);
			REG_CTRL: rd_data = WB_DW'(busy);
			default: rd_data = '0;
		endcase
	end

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			wb_ack <= 1'b0;
			cmd_go <= 1'b0;
			busy <= 1'b0;
		end
		else
		begin
			wb_ack <= access;
			cmd_go <= go;
			if (line_done)
				busy <= 1'b0;
			else if (go)
				busy <= 1'b1;
		end
	end

	// line parameters stay frozen while a line is being drawn
	always_ff @(posedge clk)
	begin
		if (access && wb_we && !busy)
		begin
			case (wb_adr)
				REG_START_X: start_x <= wb_dat_w[X_W-1:0];
				REG_START_Y: start_y <= wb_dat_w[Y_W-1:0];
				REG_END_X: end_x <= wb_dat_w[X_W-1:0];
				REG_END_Y: end_y <= wb_dat_w[Y_W-1:0];
				REG_COLOUR: colour <= wb_dat_w[COLOUR_W-1:0];
				default: ;
			endcase
		end
		if (access && !wb_we)
			wb_dat_r <= rd_data;
	end

endmodule

`default_nettype wire

/* hw/line_pkg.sv */
`default_nettype none

package line_pkg;

	// coordinate widths for a 320x240 screen
	localparam int X_W = 9;
	localparam int Y_W = 8;
	localparam int CRD_W = (X_W > Y_W) ? X_W : Y_W;

	localparam int COLOUR_W = 8;
	localparam int FB_ADR_W = 17;
	localparam int WB_DW = 16;

	// gradient and error are fixed point, one whole step is 1 << FRAC_W
	localparam int FRAC_W = 7;
	localparam int GRAD_W = 16;

	typedef enum logic [2:0] {
		REG_START_X = 3'd0,
		REG_START_Y = 3'd1,
		REG_END_X   = 3'd2,
		REG_END_Y   = 3'd3,
		REG_COLOUR  = 3'd4,
		REG_CTRL    = 3'd5
	} reg_addr_e;

	typedef enum logic [1:0] {
		STEP_IDLE,
		STEP_RUN,
		STEP_LAST
	} step_state_e;

endpackage

`default_nettype wire
